//--- Bender.yml
package:
  name: single_cpu

sources:
  - hw/cpuPkg.sv
  - hw/ctrlBus.sv
  - hw/instMem.sv
  - hw/decoder.sv
  - hw/regFile.sv
  - hw/executeUnit.sv
  - hw/dataMem.sv
  - hw/fetchUnit.sv
  - hw/singleCpu.sv
  - target: simulation
    files:
      - tb/tbClock.sv
      - tb/tbTop.sv

//--- hw/cpuPkg.sv
package cpuPkg;

    localparam int xlen     = 32;
    localparam int regAddrW = 5;
    localparam int regCount = 32;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011
    } opcodeE;

    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        SLT = 3'd4
    } aluFnE;

    typedef struct packed {
        logic [6:0]          funct7;
        logic [regAddrW-1:0] rs2;
        logic [regAddrW-1:0] rs1;
        logic [2:0]          funct3;
        logic [regAddrW-1:0] rd;
        logic [6:0]          opcode;
    } rFmtT;

    typedef struct packed {
        logic [11:0]         imm12;
        logic [regAddrW-1:0] rs1;
        logic [2:0]          funct3;
        logic [regAddrW-1:0] rd;
        logic [6:0]          opcode;
    } iFmtT;

    typedef struct packed {
        logic [6:0]          immHi;
        logic [regAddrW-1:0] rs2;
        logic [regAddrW-1:0] rs1;
        logic [2:0]          funct3;
        logic [4:0]          immLo;
        logic [6:0]          opcode;
    } sFmtT;

    // Branch offset bits are scattered over the word
    typedef struct packed {
        logic                imm12;
        logic [5:0]          imm10to5;
        logic [regAddrW-1:0] rs2;
        logic [regAddrW-1:0] rs1;
        logic [2:0]          funct3;
        logic [3:0]          imm4to1;
        logic                imm11;
        logic [6:0]          opcode;
    } bFmtT;

    typedef union packed {
        rFmtT r;
        iFmtT i;
        sFmtT s;
        bFmtT b;
    } instU;

endpackage

//--- hw/ctrlBus.sv
`timescale 1ns/1ps

interface ctrlBus;
    import cpuPkg::*;

    logic [regAddrW-1:0] rs1;
    logic [regAddrW-1:0] rs2;
    logic [regAddrW-1:0] rd;
    logic [xlen-1:0]     imm;      // Already sign-extended
    aluFnE               aluFn;
    logic                aluSrc;   // Immediate as second operand
    logic                regWrite; // Never set for x0
    logic                memWrite;
    logic                memToReg;
    logic                branch;

    modport dec (
        output rs1, rs2, rd, imm, aluFn, aluSrc,
        output regWrite, memWrite, memToReg, branch
    );

    modport dp (
        input rs1, rs2, rd, imm, aluFn, aluSrc,
        input regWrite, memWrite, memToReg, branch
    );

endinterface

//--- hw/dataMem.sv
`timescale 1ns/1ps

module dataMem #(
    parameter int dmemWords = 64
) (
    input  logic                    CLK,
    input  logic                    arstN,
    input  logic [cpuPkg::xlen-1:0] aluOut,    // Byte address
    input  logic [cpuPkg::xlen-1:0] storeData,
    ctrlBus.dp                      ctl,
    output logic [cpuPkg::xlen-1:0] loadData
);
    import cpuPkg::*;

    localparam int addrW = $clog2(dmemWords);

    logic [xlen-1:0]  mem [dmemWords];
    logic [addrW-1:0] idx;

    assign idx = aluOut[addrW+1:2];

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < dmemWords; i++) begin
                mem[i] <= '0;
            end
        end else if (ctl.memWrite) begin
            mem[idx] <= storeData;
        end
    end

    assign loadData = mem[idx];

    // Store address computed from rs1 + imm must land inside the array
    storeInRange: assert property (
        @(posedge CLK) disable iff (!arstN)
        ctl.memWrite |-> (aluOut[xlen-1:2] < dmemWords)
    ) else $error("dataMem: store to word %0d out of range", aluOut[xlen-1:2]);

endmodule

//--- hw/decoder.sv
`timescale 1ns/1ps

module decoder (
    input  logic         run,
    input  cpuPkg::instU inst,
    ctrlBus.dec          ctl
);
    import cpuPkg::*;

    logic            regWant;
    logic            memWant;
    logic            brWant;
    logic [xlen-1:0] immI;
    logic [xlen-1:0] immS;
    logic [xlen-1:0] immB;

    // R-type ALU function from funct3 and funct7 bit 5
    function automatic aluFnE opAluFn(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? SUB : ADD;
            3'b010:  return SLT;
            3'b110:  return OR;
            3'b111:  return AND;
            default: return ADD;
        endcase
    endfunction

    // One immediate per format, each read through its own view
    assign immI = {{20{inst.i.imm12[11]}}, inst.i.imm12};
    assign immS = {{20{inst.s.immHi[6]}}, inst.s.immHi, inst.s.immLo};
    assign immB = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                   inst.b.imm10to5, inst.b.imm4to1, 1'b0};

    // Register fields sit in the same bits for every format
    assign ctl.rs1 = inst.r.rs1;
    assign ctl.rs2 = inst.r.rs2;
    assign ctl.rd  = inst.r.rd;

    always_comb begin
        ctl.imm      = '0;
        ctl.aluFn    = ADD;
        ctl.aluSrc   = 1'b0;
        ctl.memToReg = 1'b0;
        regWant      = 1'b0;
        memWant      = 1'b0;
        brWant       = 1'b0;

        case (inst.r.opcode)
            OP: begin
                ctl.aluFn = opAluFn(inst.r.funct3, inst.r.funct7[5]);
                regWant   = 1'b1;
            end
            OP_IMM: begin // Only addi in the subset
                ctl.imm    = immI;
                ctl.aluSrc = 1'b1;
                regWant    = 1'b1;
            end
            LOAD: begin
                ctl.imm      = immI;
                ctl.aluSrc   = 1'b1;
                ctl.memToReg = 1'b1;
                regWant      = 1'b1;
            end
            STORE: begin
                ctl.imm    = immS;
                ctl.aluSrc = 1'b1;
                memWant    = 1'b1;
            end
            BRANCH: begin
                ctl.imm   = immB;
                ctl.aluFn = SUB; // Zero result means equal
                brWant    = 1'b1;
            end
            default: begin
                // Unknown opcode falls through as a nop
            end
        endcase
    end

    // Nothing commits while the core is stopped
    assign ctl.regWrite = run && regWant && (inst.r.rd != '0);
    assign ctl.memWrite = run && memWant;
    assign ctl.branch   = run && brWant;

endmodule

//--- hw/executeUnit.sv
`timescale 1ns/1ps

module executeUnit (
    input  logic [cpuPkg::xlen-1:0] rd1,
    input  logic [cpuPkg::xlen-1:0] rd2,
    input  logic [cpuPkg::xlen-1:0] loadData,
    ctrlBus.dp                      ctl,
    output logic [cpuPkg::xlen-1:0] aluOut,
    output logic                    zero,
    output logic [cpuPkg::xlen-1:0] wbData
);
    import cpuPkg::*;

    logic [xlen-1:0] opB;

    assign opB = ctl.aluSrc ? ctl.imm : rd2;

    always_comb begin
        case (ctl.aluFn)
            ADD:     aluOut = rd1 + opB;
            SUB:     aluOut = rd1 - opB;
            AND:     aluOut = rd1 & opB;
            OR:      aluOut = rd1 | opB;
            SLT: begin // Signed compare
                aluOut = '0;
                aluOut[0] = $signed(rd1) < $signed(opB);
            end
            default: aluOut = '0;
        endcase
    end

    assign zero = (aluOut == '0); // beq uses SUB

    // Loads return memory data, everything else the ALU result
    assign wbData = ctl.memToReg ? loadData : aluOut;

endmodule

//--- hw/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit (
    input  logic                    CLK,
    input  logic                    arstN,
    input  logic                    run,
    input  logic                    zero,
    ctrlBus.dp                      ctl,
    output logic [cpuPkg::xlen-1:0] pc
);
    import cpuPkg::*;

    logic [xlen-1:0] pcPlus4;
    logic [xlen-1:0] branchTarget;
    logic            takeBranch;

    assign pcPlus4      = pc + xlen'(4);
    assign branchTarget = pc + ctl.imm; // B immediate, pc relative
    assign takeBranch   = ctl.branch && zero;

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (run) begin // Hold while stopped
            pc <= takeBranch ? branchTarget : pcPlus4;
        end
    end

    // Branch offsets only have bit 0 cleared, so a bad target shows up here
    pcAligned: assert property (
        @(posedge CLK) disable iff (!arstN)
        pc[1:0] == 2'b00
    ) else $error("fetchUnit: misaligned pc %h", pc);

endmodule

//--- hw/instMem.sv
`timescale 1ns/1ps

module instMem #(
    parameter int imemWords = 256
) (
    input  logic                    CLK,
    input  logic                    progWe,
    input  logic [cpuPkg::xlen-1:0] progAddr, // Byte address, like pc
    input  logic [cpuPkg::xlen-1:0] progData,
    input  logic [cpuPkg::xlen-1:0] pc,
    output cpuPkg::instU            inst
);
    import cpuPkg::*;

    localparam int addrW = $clog2(imemWords);

    logic [xlen-1:0]  mem [imemWords];
    logic [addrW-1:0] wrIdx;
    logic [addrW-1:0] rdIdx;

    // Upper address bits dropped, so addresses wrap
    assign wrIdx = progAddr[addrW+1:2];
    assign rdIdx = pc[addrW+1:2];

    // Program load port
    always_ff @(posedge CLK) begin
        if (progWe) begin
            mem[wrIdx] <= progData;
        end
    end

    assign inst = mem[rdIdx]; // Asynchronous fetch

endmodule

//--- hw/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                    CLK,
    input  logic                    arstN,
    input  logic [cpuPkg::xlen-1:0] wbData,
    ctrlBus.dp                      ctl,
    output logic [cpuPkg::xlen-1:0] rd1,
    output logic [cpuPkg::xlen-1:0] rd2
);
    import cpuPkg::*;

    // x0 has no storage
    logic [xlen-1:0] regs [1:regCount-1];

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (ctl.regWrite) begin
            regs[ctl.rd] <= wbData;
        end
    end

    always_comb begin
        rd1 = '0;
        rd2 = '0;
        if (ctl.rs1 != '0) begin
            rd1 = regs[ctl.rs1];
        end
        if (ctl.rs2 != '0) begin
            rd2 = regs[ctl.rs2];
        end
    end

    // Decoder must have filtered x0 writes out
    noX0Write: assert property (
        @(posedge CLK) disable iff (!arstN)
        ctl.regWrite |-> (ctl.rd != '0)
    ) else $error("regFile: write strobe with rd = x0");

endmodule

//--- hw/singleCpu.sv
`timescale 1ns/1ps

module singleCpu #(
    parameter int imemWords = 256,
    parameter int dmemWords = 64
) (
    input  logic                        CLK,
    input  logic                        arstN,
    input  logic                        run,
    input  logic                        progWe,
    input  logic [cpuPkg::xlen-1:0]     progAddr,
    input  logic [cpuPkg::xlen-1:0]     progData,
    output logic [cpuPkg::xlen-1:0]     pc,
    output logic                        wbEn,
    output logic [cpuPkg::regAddrW-1:0] wbAddr,
    output logic [cpuPkg::xlen-1:0]     wbData,
    output logic                        stEn,
    output logic [cpuPkg::xlen-1:0]     stAddr,
    output logic [cpuPkg::xlen-1:0]     stData
);
    import cpuPkg::*;

    instU            inst;
    logic [xlen-1:0] rd1;
    logic [xlen-1:0] rd2;
    logic [xlen-1:0] aluOut;
    logic [xlen-1:0] loadData;
    logic            zero;

    ctrlBus ctl ();

    fetchUnit uFetch (
        .CLK, .arstN, .run, .zero,
        .ctl (ctl.dp),
        .pc
    );

    instMem #(.imemWords(imemWords)) uImem (
        .CLK, .progWe, .progAddr, .progData, .pc,
        .inst
    );

    decoder uDec (.run, .inst, .ctl(ctl.dec));

    regFile uRegs (
        .CLK, .arstN, .wbData,
        .ctl (ctl.dp),
        .rd1, .rd2
    );

    executeUnit uExec (
        .rd1, .rd2, .loadData,
        .ctl (ctl.dp),
        .aluOut, .zero, .wbData
    );

    dataMem #(.dmemWords(dmemWords)) uDmem (
        .CLK, .arstN, .aluOut,
        .storeData (rd2),
        .ctl       (ctl.dp),
        .loadData
    );

    // Commit view of the instruction at the current pc
    assign wbEn   = ctl.regWrite;
    assign wbAddr = ctl.rd;
    assign stEn   = ctl.memWrite;
    assign stAddr = aluOut;
    assign stData = rd2;

endmodule

//--- tb.f
hw/cpuPkg.sv
hw/ctrlBus.sv
hw/instMem.sv
hw/decoder.sv
hw/regFile.sv
hw/executeUnit.sv
hw/dataMem.sv
hw/fetchUnit.sv
hw/singleCpu.sv
tb/tbClock.sv
tb/tbTop.sv

//--- tb/tbClock.sv
`timescale 1ns/1ps

module tbClock #(
    parameter int halfPeriod  = 5, // 10 ns clock
    parameter int resetCycles = 8
) (
    output logic CLK,
    output logic arstN
);

    initial begin
        CLK = 1'b0;
        forever #halfPeriod CLK = ~CLK;
    end

    // Reset released on a falling edge, clear of the rising edge
    initial begin
        arstN = 1'b0;
        repeat (resetCycles) @(posedge CLK);
        @(negedge CLK);
        arstN = 1'b1;
    end

endmodule

//--- tb/tbTop.sv
`timescale 1ns/1ps

module tbTop;

    localparam int imemWords    = 256;
    localparam int dmemWords    = 64;
    localparam int progLen      = 96;
    localparam int runTimeout   = 4 * progLen;
    localparam int resetTimeout = 50;

    // Opcodes as the ISA defines them
    localparam logic [6:0] opReg    = 7'b0110011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opCustom = 7'b0001011; // Not in the subset

    logic        CLK;
    logic        arstN;
    logic        run;
    logic        progWe;
    logic [31:0] progAddr;
    logic [31:0] progData;
    logic [31:0] pc;
    logic        wbEn;
    logic [4:0]  wbAddr;
    logic [31:0] wbData;
    logic        stEn;
    logic [31:0] stAddr;
    logic [31:0] stData;

    logic [31:0] lfsr;
    logic [31:0] prog [progLen];

    // Reference model state
    logic [31:0] modelPc;
    logic [31:0] modelRegs [32];
    logic [31:0] modelMem [dmemWords];

    // Prediction for the instruction at modelPc
    logic        expWbEn;
    logic [4:0]  expWbAddr;
    logic [31:0] expWbData;
    logic        expStEn;
    logic [31:0] expStAddr;
    logic [31:0] expStData;
    logic [31:0] expNextPc;

    int mismatches;
    int failures;
    int checks;

    tbClock clkGen (.CLK, .arstN);

    singleCpu #(.imemWords(imemWords), .dmemWords(dmemWords)) dut0 (
        .CLK, .arstN, .run, .progWe, .progAddr, .progData,
        .pc, .wbEn, .wbAddr, .wbData, .stEn, .stAddr, .stData
    );

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    task automatic drawBits(input int n, output logic [31:0] val);
        logic fb;
        val = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
    endtask

    task automatic genProgram();
        logic [31:0] kind;
        logic [31:0] rd;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] same;
        logic [31:0] rnd;
        logic [12:0] off;
        for (int i = 0; i < progLen; i++) begin
            drawBits(4, kind);
            drawBits(3, rd); // x0..x7 keeps dependencies dense
            drawBits(3, rs1);
            drawBits(3, rs2);
            if (kind >= 12 && kind <= 13) begin
                drawBits(1, same);
                drawBits(2, rnd);
                off = 13'((rnd + 1) * 4);
                if (same[0]) begin
                    rs2 = rs1;
                end
                if (i + rnd + 1 > progLen - 1) begin
                    kind = 15; // Target would leave the program
                end
            end
            case (kind)
                0: prog[i] = {7'b0000000, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], opReg};
                1: prog[i] = {7'b0100000, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], opReg};
                2: prog[i] = {7'b0000000, rs2[4:0], rs1[4:0], 3'b111, rd[4:0], opReg};
                3: prog[i] = {7'b0000000, rs2[4:0], rs1[4:0], 3'b110, rd[4:0], opReg};
                4: prog[i] = {7'b0000000, rs2[4:0], rs1[4:0], 3'b010, rd[4:0], opReg};
                8, 9: begin // lw from x0, small window to hit earlier stores
                    drawBits(3, rnd);
                    prog[i] = {7'd0, rnd[2:0], 2'b00, 5'd0, 3'b010, rd[4:0], opLoad};
                end
                10, 11: begin
                    drawBits(3, rnd);
                    off     = 13'(rnd * 4);
                    prog[i] = {off[11:5], rs2[4:0], 5'd0, 3'b010, off[4:0], opStore};
                end
                12, 13: prog[i] = {off[12], off[10:5], rs2[4:0], rs1[4:0], 3'b000,
                                   off[4:1], off[11], opBranch};
                14: begin
                    drawBits(25, rnd);
                    prog[i] = {rnd[24:0], opCustom};
                end
                default: begin // addi
                    drawBits(12, rnd);
                    prog[i] = {rnd[11:0], rs1[4:0], 3'b000, rd[4:0], opImm};
                end
            endcase
        end
    endtask

    // ISA semantics of the instruction at modelPc
    task automatic predict();
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        w    = prog[modelPc[31:2]];
        a    = (w[19:15] == 5'd0) ? 32'd0 : modelRegs[w[19:15]];
        b    = (w[24:20] == 5'd0) ? 32'd0 : modelRegs[w[24:20]];
        immI = {{20{w[31]}}, w[31:20]};
        immS = {{20{w[31]}}, w[31:25], w[11:7]};
        immB = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        expWbEn   = 1'b0;
        expWbAddr = w[11:7];
        expWbData = '0;
        expStEn   = 1'b0;
        expStAddr = '0;
        expStData = '0;
        expNextPc = modelPc + 4;
        case (w[6:0])
            opReg: begin
                case ({w[30], w[14:12]})
                    4'b0000: expWbData = a + b;
                    4'b1000: expWbData = a - b;
                    4'b0111: expWbData = a & b;
                    4'b0110: expWbData = a | b;
                    default: expWbData = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                endcase
                expWbEn = (w[11:7] != 5'd0);
            end
            opImm: begin
                expWbData = a + immI;
                expWbEn   = (w[11:7] != 5'd0);
            end
            opLoad: begin
                expWbData = modelMem[(a + immI) >> 2];
                expWbEn   = (w[11:7] != 5'd0);
            end
            opStore: begin
                expStEn   = 1'b1;
                expStAddr = a + immS;
                expStData = b;
            end
            opBranch: begin
                if (a == b) begin
                    expNextPc = modelPc + immB;
                end
            end
            default: begin
                // Anything else only advances pc
            end
        endcase
    endtask

    task automatic commit();
        if (expWbEn) begin
            modelRegs[expWbAddr] = expWbData;
        end
        if (expStEn) begin
            modelMem[expStAddr >> 2] = expStData;
        end
        modelPc = expNextPc;
    endtask

    task automatic checkValue(input string name, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        checks++;
        if (actVal !== expVal) begin
            $display("mismatch %s: expected %h actual %h", name, expVal, actVal);
            mismatches++;
        end
    endtask

    // Stopped core, pc held and no write strobes
    task automatic checkIdle(input string name);
        checkValue({name, " pc"}, modelPc, pc);
        checkValue({name, " wbEn"}, 32'd0, {31'd0, wbEn});
        checkValue({name, " stEn"}, 32'd0, {31'd0, stEn});
    endtask

    task automatic checkStep(input int step);
        string tag;
        tag = $sformatf("step %0d", step);
        checkValue({tag, " pc"}, modelPc, pc);
        checkValue({tag, " wbEn"}, {31'd0, expWbEn}, {31'd0, wbEn});
        if (expWbEn) begin
            checkValue({tag, " wbAddr"}, {27'd0, expWbAddr}, {27'd0, wbAddr});
            checkValue({tag, " wbData"}, expWbData, wbData);
        end
        checkValue({tag, " stEn"}, {31'd0, expStEn}, {31'd0, stEn});
        if (expStEn) begin
            checkValue({tag, " stAddr"}, expStAddr, stAddr);
            checkValue({tag, " stData"}, expStData, stData);
        end
    endtask

    task automatic loadProgram();
        for (int i = 0; i < progLen; i++) begin
            @(negedge CLK);
            progWe   = 1'b1;
            progAddr = 32'(i * 4);
            progData = prog[i];
            #1;
            checkIdle($sformatf("load %0d", i));
        end
        @(negedge CLK);
        progWe = 1'b0;
    endtask

    task automatic runProgram();
        int cycle;
        cycle = 0;
        while (modelPc < progLen * 4 && cycle < runTimeout) begin
            @(negedge CLK);
            run = 1'b1;
            #1; // Let the combinational outputs settle
            predict();
            checkStep(cycle);
            commit();
            cycle++;
        end
        if (modelPc < progLen * 4) begin
            $display("timeout: program did not finish within %0d cycles, model pc %h",
                     runTimeout, modelPc);
            failures++;
        end
        @(negedge CLK);
        run = 1'b0;
    endtask

    initial begin
        int waitCycles;
        run      = 1'b0;
        progWe   = 1'b0;
        progAddr = '0;
        progData = '0;
        lfsr       = 32'hecbc;
        mismatches = 0;
        failures   = 0;
        checks     = 0;
        modelPc    = '0;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        for (int i = 0; i < dmemWords; i++) begin
            modelMem[i] = '0;
        end
        genProgram();

        waitCycles = 0;
        while (arstN !== 1'b1 && waitCycles < resetTimeout) begin
            @(posedge CLK);
            waitCycles++;
        end
        if (arstN !== 1'b1) begin
            $display("timeout: reset was never released");
            failures++;
        end else begin
            loadProgram();
            repeat (3) begin
                @(negedge CLK);
                #1;
                checkIdle("before run");
            end
            runProgram();
            repeat (3) begin // pc must hold once run drops
                @(negedge CLK);
                #1;
                checkIdle("after run");
            end
        end

        $display("checks %0d, mismatches %0d, other failures %0d",
                 checks, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
